// File: hw/PipelineTypes.sv
// Width parameters, operation-class enum and trap-cause enum for the operand-fetch pipeline.
`default_nettype none

package PipelineTypes;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 32; // integer register width.
    localparam int FLEN       = 64; // floating-point register width, wide enough for doubles.
    localparam int REG_ADDR_W = 5;  // 32 architectural registers per file.
    localparam int INSN_W     = 32;
    localparam int CSR_ADDR_W = 12;

    ////////////////////////////////////////////////////////////////////////////
    // Decoded types
    ////////////////////////////////////////////////////////////////////////////

    // OP_NONE is zero so that a cleared stage reads as a bubble.
    typedef enum logic [3:0] {
        OP_NONE     = 4'd0,
        OP_INT_REG  = 4'd1,
        OP_INT_IMM  = 4'd2,
        OP_LOAD     = 4'd3,
        OP_STORE    = 4'd4,
        OP_BRANCH   = 4'd5,
        OP_FP_ARITH = 4'd6,
        OP_FP_FMA   = 4'd7,
        OP_CSR      = 4'd8,
        OP_ILLEGAL  = 4'd9
    } OpClass;

    typedef enum logic [1:0] {
        TRAP_NONE         = 2'd0,
        TRAP_ILLEGAL_INSN = 2'd1 // raised for any opcode outside the supported set.
    } TrapCause;

endpackage

`default_nettype wire

// File: hw/DecodeStage.sv
// Registered decoder producing register addresses, CSR address, operation class and trap cause.
`default_nettype none

module DecodeStage (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      stall,
    input  logic                                      flush,
    input  logic                                      insnValid,
    input  logic [PipelineTypes::INSN_W-1:0]          insn,
    input  logic [PipelineTypes::XLEN-1:0]            pc,
    output logic                                      decodeValid,
    output PipelineTypes::OpClass                     decodeOp,
    output logic [PipelineTypes::XLEN-1:0]            decodePc,
    output logic [PipelineTypes::INSN_W-1:0]          decodeInsn,
    output logic [PipelineTypes::CSR_ADDR_W-1:0]      decodeCsrAddr,
    output logic [PipelineTypes::REG_ADDR_W-1:0]      decodeSrcRegAddr1,
    output logic [PipelineTypes::REG_ADDR_W-1:0]      decodeSrcRegAddr2,
    output logic [PipelineTypes::REG_ADDR_W-1:0]      decodeSrcRegAddr3,
    output logic [PipelineTypes::REG_ADDR_W-1:0]      decodeDstRegAddr,
    output PipelineTypes::TrapCause                   decodeTrapCause
);
    import PipelineTypes::*;

    OpClass   nextOp;
    TrapCause nextTrap;

    ////////////////////////////////////////////////////////////////////////////
    // Opcode classification
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        nextOp   = OP_NONE;   // an empty slot decodes as a bubble.
        nextTrap = TRAP_NONE;
        if (insnValid) begin
            case (insn[6:0])
                7'b0110011: nextOp = OP_INT_REG;
                7'b0010011: nextOp = OP_INT_IMM;
                7'b0000011: nextOp = OP_LOAD;
                7'b0100011: nextOp = OP_STORE;
                7'b1100011: nextOp = OP_BRANCH;
                7'b1010011: nextOp = OP_FP_ARITH;
                // fmadd, fmsub, fnmsub and fnmadd share one class.
                7'b1000011, 7'b1000111, 7'b1001011, 7'b1001111: nextOp = OP_FP_FMA;
                7'b1110011: nextOp = OP_CSR;
                default: begin
                    nextOp   = OP_ILLEGAL; // still travels as valid so the trap can be taken later.
                    nextTrap = TRAP_ILLEGAL_INSN;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            decodeValid       <= 1'b0;
            decodeOp          <= OP_NONE;
            decodePc          <= '0;
            decodeInsn        <= '0;
            decodeCsrAddr     <= '0;
            decodeSrcRegAddr1 <= '0;
            decodeSrcRegAddr2 <= '0;
            decodeSrcRegAddr3 <= '0;
            decodeDstRegAddr  <= '0;
            decodeTrapCause   <= TRAP_NONE;
        end
        else if (!stall) begin
            decodeValid       <= insnValid;
            decodeOp          <= nextOp;
            decodePc          <= pc;
            decodeInsn        <= insn;           // raw word carries the immediates onward.
            decodeCsrAddr     <= insn[31:20];
            decodeSrcRegAddr1 <= insn[19:15];
            decodeSrcRegAddr2 <= insn[24:20];
            decodeSrcRegAddr3 <= insn[31:27];    // rs3 of the fused multiply-add format.
            decodeDstRegAddr  <= insn[11:7];
            decodeTrapCause   <= nextTrap;
        end
    end

    // the trap cause must stay in step with the operation class across every update.
    assert property (@(posedge clk) disable iff (rst)
        (decodeOp == OP_ILLEGAL) == (decodeTrapCause == TRAP_ILLEGAL_INSN));

endmodule

`default_nettype wire

// File: hw/IntRegFile.sv
// Integer register file with two asynchronous read ports, one write port and x0 tied to zero.
`default_nettype none

module IntRegFile #(
    parameter int XLEN       = PipelineTypes::XLEN,
    parameter int REG_ADDR_W = PipelineTypes::REG_ADDR_W
) (
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] readAddr1,
    input  logic [REG_ADDR_W-1:0] readAddr2,
    output logic [XLEN-1:0]       readValue1,
    output logic [XLEN-1:0]       readValue2,
    input  logic                  writeEnable,
    input  logic [REG_ADDR_W-1:0] writeAddr,
    input  logic [XLEN-1:0]       writeValue
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // x0 is never written, so the read mux supplies its zero.
    assign readValue1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
    assign readValue2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

    always_ff @(posedge clk) begin
        if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeValue; // same-cycle readers still see the old value.
        end
    end

    // an unknown address would silently corrupt an arbitrary register.
    assert property (@(posedge clk) writeEnable |-> !$isunknown(writeAddr));

endmodule

`default_nettype wire

// File: hw/FpRegFile.sv
// Floating-point register file with three asynchronous read ports and one write port.
`default_nettype none

module FpRegFile #(
    parameter int FLEN       = PipelineTypes::FLEN,
    parameter int REG_ADDR_W = PipelineTypes::REG_ADDR_W
) (
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] readAddr1,
    input  logic [REG_ADDR_W-1:0] readAddr2,
    input  logic [REG_ADDR_W-1:0] readAddr3,
    output logic [FLEN-1:0]       readValue1,
    output logic [FLEN-1:0]       readValue2,
    output logic [FLEN-1:0]       readValue3,
    input  logic                  writeEnable,
    input  logic [REG_ADDR_W-1:0] writeAddr,
    input  logic [FLEN-1:0]       writeValue
);

    logic [FLEN-1:0] regs [2**REG_ADDR_W];

    // third port serves rs3 of fused multiply-add.
    assign readValue1 = regs[readAddr1];
    assign readValue2 = regs[readAddr2];
    assign readValue3 = regs[readAddr3];

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            regs[writeAddr] <= writeValue; // f0 is an ordinary register.
        end
    end

    // an unknown address would silently corrupt an arbitrary register.
    assert property (@(posedge clk) writeEnable |-> !$isunknown(writeAddr));

endmodule

`default_nettype wire

// File: hw/RegReadStage.sv
// Register-read stage that addresses both register files and registers operands and fields.
`default_nettype none

module RegReadStage #(
    parameter int XLEN       = PipelineTypes::XLEN,
    parameter int FLEN       = PipelineTypes::FLEN,
    parameter int REG_ADDR_W = PipelineTypes::REG_ADDR_W
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 stall,
    input  logic                                 flush,
    input  logic                                 decodeValid,
    input  PipelineTypes::OpClass                decodeOp,
    input  logic [XLEN-1:0]                      decodePc,
    input  logic [PipelineTypes::INSN_W-1:0]     decodeInsn,
    input  logic [PipelineTypes::CSR_ADDR_W-1:0] decodeCsrAddr,
    input  logic [REG_ADDR_W-1:0]                decodeSrcRegAddr1,
    input  logic [REG_ADDR_W-1:0]                decodeSrcRegAddr2,
    input  logic [REG_ADDR_W-1:0]                decodeSrcRegAddr3,
    input  logic [REG_ADDR_W-1:0]                decodeDstRegAddr,
    input  PipelineTypes::TrapCause              decodeTrapCause,
    output logic [REG_ADDR_W-1:0]                intReadAddr1,
    output logic [REG_ADDR_W-1:0]                intReadAddr2,
    input  logic [XLEN-1:0]                      intReadValue1,
    input  logic [XLEN-1:0]                      intReadValue2,
    output logic [REG_ADDR_W-1:0]                fpReadAddr1,
    output logic [REG_ADDR_W-1:0]                fpReadAddr2,
    output logic [REG_ADDR_W-1:0]                fpReadAddr3,
    input  logic [FLEN-1:0]                      fpReadValue1,
    input  logic [FLEN-1:0]                      fpReadValue2,
    input  logic [FLEN-1:0]                      fpReadValue3,
    output logic                                 rrValid,
    output PipelineTypes::OpClass                rrOp,
    output logic [XLEN-1:0]                      rrPc,
    output logic [PipelineTypes::INSN_W-1:0]     rrInsn,
    output logic [PipelineTypes::CSR_ADDR_W-1:0] rrCsrAddr,
    output logic [REG_ADDR_W-1:0]                rrSrcRegAddr1,
    output logic [REG_ADDR_W-1:0]                rrSrcRegAddr2,
    output logic [REG_ADDR_W-1:0]                rrSrcRegAddr3,
    output logic [REG_ADDR_W-1:0]                rrDstRegAddr,
    output logic [XLEN-1:0]                      rrSrcIntRegValue1,
    output logic [XLEN-1:0]                      rrSrcIntRegValue2,
    output logic [FLEN-1:0]                      rrSrcFpRegValue1,
    output logic [FLEN-1:0]                      rrSrcFpRegValue2,
    output logic [FLEN-1:0]                      rrSrcFpRegValue3,
    output PipelineTypes::TrapCause              rrTrapCause
);
    import PipelineTypes::*;

    // both files are read speculatively; execute picks the operands it needs.
    assign intReadAddr1 = decodeSrcRegAddr1;
    assign intReadAddr2 = decodeSrcRegAddr2;
    assign fpReadAddr1  = decodeSrcRegAddr1;
    assign fpReadAddr2  = decodeSrcRegAddr2;
    assign fpReadAddr3  = decodeSrcRegAddr3;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rrValid           <= 1'b0;
            rrOp              <= OP_NONE;
            rrPc              <= '0;
            rrInsn            <= '0;
            rrCsrAddr         <= '0;
            rrSrcRegAddr1     <= '0;
            rrSrcRegAddr2     <= '0;
            rrSrcRegAddr3     <= '0;
            rrDstRegAddr      <= '0;
            rrSrcIntRegValue1 <= '0;
            rrSrcIntRegValue2 <= '0;
            rrSrcFpRegValue1  <= '0;
            rrSrcFpRegValue2  <= '0;
            rrSrcFpRegValue3  <= '0;
            rrTrapCause       <= TRAP_NONE;
        end
        else if (!stall) begin
            rrValid           <= decodeValid;
            rrOp              <= decodeOp;
            rrPc              <= decodePc;
            rrInsn            <= decodeInsn;
            rrCsrAddr         <= decodeCsrAddr;
            rrSrcRegAddr1     <= decodeSrcRegAddr1;
            rrSrcRegAddr2     <= decodeSrcRegAddr2;
            rrSrcRegAddr3     <= decodeSrcRegAddr3;
            rrDstRegAddr      <= decodeDstRegAddr;
            rrSrcIntRegValue1 <= intReadValue1; // operands are frozen while stalled.
            rrSrcIntRegValue2 <= intReadValue2;
            rrSrcFpRegValue1  <= fpReadValue1;
            rrSrcFpRegValue2  <= fpReadValue2;
            rrSrcFpRegValue3  <= fpReadValue3;
            rrTrapCause       <= decodeTrapCause;
        end
    end

    // flush wins over stall, so nothing survives into execute.
    assert property (@(posedge clk) disable iff (rst) flush |=> !rrValid);

endmodule

`default_nettype wire

// File: hw/RegReadTop.sv
// Top level joining the decode stage, both register files and the register-read stage.
`default_nettype none

module RegReadTop (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 stall,
    input  logic                                 flush,
    input  logic                                 insnValid,
    input  logic [PipelineTypes::INSN_W-1:0]     insn,
    input  logic [PipelineTypes::XLEN-1:0]       pc,
    input  logic                                 intWriteEnable,
    input  logic [PipelineTypes::REG_ADDR_W-1:0] intWriteAddr,
    input  logic [PipelineTypes::XLEN-1:0]       intWriteValue,
    input  logic                                 fpWriteEnable,
    input  logic [PipelineTypes::REG_ADDR_W-1:0] fpWriteAddr,
    input  logic [PipelineTypes::FLEN-1:0]       fpWriteValue,
    output logic                                 rrValid,
    output PipelineTypes::OpClass                rrOp,
    output logic [PipelineTypes::XLEN-1:0]       rrPc,
    output logic [PipelineTypes::INSN_W-1:0]     rrInsn,
    output logic [PipelineTypes::CSR_ADDR_W-1:0] rrCsrAddr,
    output logic [PipelineTypes::REG_ADDR_W-1:0] rrSrcRegAddr1,
    output logic [PipelineTypes::REG_ADDR_W-1:0] rrSrcRegAddr2,
    output logic [PipelineTypes::REG_ADDR_W-1:0] rrSrcRegAddr3,
    output logic [PipelineTypes::REG_ADDR_W-1:0] rrDstRegAddr,
    output logic [PipelineTypes::XLEN-1:0]       rrSrcIntRegValue1,
    output logic [PipelineTypes::XLEN-1:0]       rrSrcIntRegValue2,
    output logic [PipelineTypes::FLEN-1:0]       rrSrcFpRegValue1,
    output logic [PipelineTypes::FLEN-1:0]       rrSrcFpRegValue2,
    output logic [PipelineTypes::FLEN-1:0]       rrSrcFpRegValue3,
    output PipelineTypes::TrapCause              rrTrapCause
);
    import PipelineTypes::*;

    ////////////////////////////////////////////////////////////////////////////
    // Decode to register-read signals
    ////////////////////////////////////////////////////////////////////////////

    logic                  decodeValid;
    OpClass                decodeOp;
    logic [XLEN-1:0]       decodePc;
    logic [INSN_W-1:0]     decodeInsn;
    logic [CSR_ADDR_W-1:0] decodeCsrAddr;
    logic [REG_ADDR_W-1:0] decodeSrcRegAddr1;
    logic [REG_ADDR_W-1:0] decodeSrcRegAddr2;
    logic [REG_ADDR_W-1:0] decodeSrcRegAddr3;
    logic [REG_ADDR_W-1:0] decodeDstRegAddr;
    TrapCause              decodeTrapCause;

    logic [REG_ADDR_W-1:0] intReadAddr1, intReadAddr2;
    logic [XLEN-1:0]       intReadValue1, intReadValue2;
    logic [REG_ADDR_W-1:0] fpReadAddr1, fpReadAddr2, fpReadAddr3;
    logic [FLEN-1:0]       fpReadValue1, fpReadValue2, fpReadValue3;

    DecodeStage decode_i (.*);

    IntRegFile #(.XLEN(XLEN), .REG_ADDR_W(REG_ADDR_W)) intRegFile_i (
        .clk, .readAddr1(intReadAddr1), .readAddr2(intReadAddr2),
        .readValue1(intReadValue1), .readValue2(intReadValue2),
        .writeEnable(intWriteEnable), .writeAddr(intWriteAddr), .writeValue(intWriteValue)
    );

    FpRegFile #(.FLEN(FLEN), .REG_ADDR_W(REG_ADDR_W)) fpRegFile_i (
        .clk, .readAddr1(fpReadAddr1), .readAddr2(fpReadAddr2), .readAddr3(fpReadAddr3),
        .readValue1(fpReadValue1), .readValue2(fpReadValue2), .readValue3(fpReadValue3),
        .writeEnable(fpWriteEnable), .writeAddr(fpWriteAddr), .writeValue(fpWriteValue)
    );

    // every remaining port name matches a net here one to one.
    RegReadStage #(.XLEN(XLEN), .FLEN(FLEN), .REG_ADDR_W(REG_ADDR_W)) regRead_i (.*);

endmodule

`default_nettype wire

// File: tests/RegReadTopTb.sv
// Directed testbench for RegReadTop with clock, reset, xorshift, register model, checks and timeout.
`default_nettype none

module RegReadTopTb;
    timeunit 1ns;
    timeprecision 1ps;
    import PipelineTypes::*;

    localparam int TIMEOUT_CYCLES = 400; // the tests take about 130 cycles.

    logic                  clk, rst, stall, flush, insnValid;
    logic [INSN_W-1:0]     insn;
    logic [XLEN-1:0]       pc;
    logic                  intWriteEnable, fpWriteEnable;
    logic [REG_ADDR_W-1:0] intWriteAddr, fpWriteAddr;
    logic [XLEN-1:0]       intWriteValue;
    logic [FLEN-1:0]       fpWriteValue;
    logic                  rrValid;
    OpClass                rrOp;
    logic [XLEN-1:0]       rrPc;
    logic [INSN_W-1:0]     rrInsn;
    logic [CSR_ADDR_W-1:0] rrCsrAddr;
    logic [REG_ADDR_W-1:0] rrSrcRegAddr1, rrSrcRegAddr2, rrSrcRegAddr3, rrDstRegAddr;
    logic [XLEN-1:0]       rrSrcIntRegValue1, rrSrcIntRegValue2;
    logic [FLEN-1:0]       rrSrcFpRegValue1, rrSrcFpRegValue2, rrSrcFpRegValue3;
    TrapCause              rrTrapCause;

    logic [XLEN-1:0] intModel [32];
    logic [FLEN-1:0] fpModel [32];
    logic [31:0]     rngState = 32'hf6f7;
    int              errorCount = 0;
    int              checkCount = 0;
    int              cycleCount = 0;

    // listed opcodes in table order, FMA at indices 6 to 9, then one unlisted opcode.
    logic [6:0] opcodes [12] = '{7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011,
                                 7'b1100011, 7'b1010011, 7'b1000011, 7'b1000111,
                                 7'b1001011, 7'b1001111, 7'b1110011, 7'b1111111};

    RegReadTop dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount == TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles.", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] randomWord();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [31:0] makeInsn(input logic [6:0] opcode);
        logic [31:0] word;
        word = randomWord();
        return {word[31:7], opcode}; // every other field is random.
    endfunction

    function automatic OpClass classifyOpcode(input logic [6:0] opcode);
        case (opcode)
            7'b0110011: return OP_INT_REG;
            7'b0010011: return OP_INT_IMM;
            7'b0000011: return OP_LOAD;
            7'b0100011: return OP_STORE;
            7'b1100011: return OP_BRANCH;
            7'b1010011: return OP_FP_ARITH;
            7'b1000011, 7'b1000111, 7'b1001011, 7'b1001111: return OP_FP_FMA;
            7'b1110011: return OP_CSR;
            default: return OP_ILLEGAL;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic driveInsn(input logic valid, input logic [31:0] word, input logic [31:0] addr);
        insnValid = valid;
        insn      = word;
        pc        = addr;
    endtask

    // compares every rr output with the decoding rule and the register model.
    task automatic checkOutputs(input logic [31:0] word, input logic [31:0] addr);
        OpClass   op;
        TrapCause trap;
        op   = classifyOpcode(word[6:0]);
        trap = (op == OP_ILLEGAL) ? TRAP_ILLEGAL_INSN : TRAP_NONE;
        checkValue("rrValid", rrValid, 1'b1);
        checkValue("rrOp", rrOp, op);
        checkValue("rrTrapCause", rrTrapCause, trap);
        checkValue("rrPc", rrPc, addr);
        checkValue("rrInsn", rrInsn, word);
        checkValue("rrCsrAddr", rrCsrAddr, word[31:20]);
        checkValue("rrDstRegAddr", rrDstRegAddr, word[11:7]);
        checkValue("rrSrcRegAddr1", rrSrcRegAddr1, word[19:15]);
        checkValue("rrSrcRegAddr2", rrSrcRegAddr2, word[24:20]);
        checkValue("rrSrcRegAddr3", rrSrcRegAddr3, word[31:27]);
        checkValue("rrSrcIntRegValue1", rrSrcIntRegValue1, intModel[word[19:15]]);
        checkValue("rrSrcIntRegValue2", rrSrcIntRegValue2, intModel[word[24:20]]);
        checkValue("rrSrcFpRegValue1", rrSrcFpRegValue1, fpModel[word[19:15]]);
        checkValue("rrSrcFpRegValue2", rrSrcFpRegValue2, fpModel[word[24:20]]);
        checkValue("rrSrcFpRegValue3", rrSrcFpRegValue3, fpModel[word[31:27]]);
    endtask

    task automatic issueAndCheck(input logic [31:0] word, input logic [31:0] addr);
        @(negedge clk);
        driveInsn(1'b1, word, addr);
        @(negedge clk);
        insnValid = 1'b0;
        @(negedge clk);
        checkOutputs(word, addr); // two edges after sampling.
    endtask

    task automatic loadRegisterFiles();
        for (int i = 0; i < 32; i++) begin
            @(negedge clk);
            intWriteEnable = 1'b1;
            intWriteAddr   = i;
            intWriteValue  = randomWord(); // x0 gets a value too, which must be dropped.
            fpWriteEnable  = 1'b1;
            fpWriteAddr    = i;
            fpWriteValue   = {randomWord(), randomWord()};
            if (i != 0) begin
                intModel[i] = intWriteValue;
            end
            fpModel[i] = fpWriteValue;
        end
        @(negedge clk);
        intWriteEnable = 1'b0;
        fpWriteEnable  = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic testReset();
        checkValue("rrValid", rrValid, 1'b0);
        checkValue("rrOp", rrOp, OP_NONE);
        checkValue("rrTrapCause", rrTrapCause, TRAP_NONE);
    endtask

    task automatic testIntReads();
        logic [31:0] word;
        loadRegisterFiles();
        for (int i = 0; i < 8; i++) begin
            word = makeInsn(7'b0110011);
            if (i == 0) word[19:15] = '0;
            if (i == 1) word[24:20] = '0;
            issueAndCheck(word, 32'h0400 + 4 * i);
        end
    endtask

    task automatic testFpReads();
        for (int i = 6; i < 10; i++) begin
            issueAndCheck(makeInsn(opcodes[i]), 32'h0800 + 4 * i);
        end
    endtask

    task automatic testDecoding();
        for (int i = 0; i < 12; i++) begin
            issueAndCheck(makeInsn(opcodes[i]), 32'h0100 + 4 * i);
        end
    endtask

    task automatic testStreaming();
        logic [31:0] streamInsn [8];
        for (int i = 0; i < 8; i++) begin
            streamInsn[i] = makeInsn(opcodes[i % 12]);
        end
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            if (i >= 2) checkOutputs(streamInsn[i - 2], 32'h3000 + 4 * (i - 2));
            if (i < 8) driveInsn(1'b1, streamInsn[i], 32'h3000 + 4 * i);
            else insnValid = 1'b0;
        end
    endtask

    task automatic testStallFlush();
        logic [31:0] heldInsn;
        logic [31:0] nextInsn;
        heldInsn = makeInsn(7'b0110011);
        nextInsn = makeInsn(7'b1000011);
        @(negedge clk);
        driveInsn(1'b1, heldInsn, 32'h2000);
        @(negedge clk);
        driveInsn(1'b1, makeInsn(7'b0000011), 32'h2004); // sits in decode during the stall.
        @(negedge clk);
        checkOutputs(heldInsn, 32'h2000);
        stall = 1'b1;
        driveInsn(1'b1, makeInsn(7'b0010011), 32'h2008); // must be ignored while stalled.
        repeat (3) begin
            @(negedge clk);
            checkOutputs(heldInsn, 32'h2000);
        end
        flush = 1'b1;
        @(negedge clk);
        checkValue("rrValid", rrValid, 1'b0);
        checkValue("rrOp", rrOp, OP_NONE);
        checkValue("rrTrapCause", rrTrapCause, TRAP_NONE);
        checkValue("rrPc", rrPc, 32'h0);
        checkValue("rrInsn", rrInsn, 32'h0);
        checkValue("rrSrcIntRegValue1", rrSrcIntRegValue1, 32'h0);
        checkValue("rrSrcFpRegValue1", rrSrcFpRegValue1, 64'h0);
        flush     = 1'b0;
        stall     = 1'b0;
        insnValid = 1'b0;
        @(negedge clk);
        checkValue("rrValid", rrValid, 1'b0); // the decode stage was cleared as well.
        issueAndCheck(nextInsn, 32'h200c);
    endtask

    initial begin
        rst            = 1'b1;
        stall          = 1'b0;
        flush          = 1'b0;
        driveInsn(1'b0, '0, '0);
        intWriteEnable = 1'b0;
        intWriteAddr   = '0;
        intWriteValue  = '0;
        fpWriteEnable  = 1'b0;
        fpWriteAddr    = '0;
        fpWriteValue   = '0;
        intModel[0]    = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        testReset();
        testIntReads();
        testFpReads();
        testDecoding();
        testStreaming();
        testStallFlush();
        $display("Finished %0d checks with %0d errors.", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end
        else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hw/PipelineTypes.sv
hw/DecodeStage.sv
hw/IntRegFile.sv
hw/FpRegFile.sv
hw/RegReadStage.sv
hw/RegReadTop.sv
tests/RegReadTopTb.sv
